// ==== include/sha256_k.svh ====
`ifndef SHA256_K_SVH
`define SHA256_K_SVH

////////////////////////////////////////////////////////////
// SHA-256 round constants
// First 32 bits of the fractional parts of the cube roots
// of the first 64 primes

// Rounds 0 to 15
localparam sha_pkg::word_t sha256_k [64] = '{
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
	32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
	32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
	// Rounds 16 to 31
	32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
	32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
	32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
	// Rounds 32 to 47
	32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
	32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
	32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	// Rounds 48 to 63
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
	32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
	32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

////////////////////////////////////////////////////////////
// Initial hash values
// Fractional parts of the square roots of the first 8 primes

// Index 0 is word a, index 7 is word h
localparam sha_pkg::word_t sha256_h0 [8] = '{
	32'h6a09e667,
	32'hbb67ae85,
	32'h3c6ef372,
	32'ha54ff53a,
	32'h510e527f,
	32'h9b05688c,
	32'h1f83d9ab,
	32'h5be0cd19
};

`endif

// ==== hw/sha_pkg.sv ====
`default_nettype none

package sha_pkg;

	////////////////////////////////////////////////////////////
	// Widths that carry a meaning

	// One message or hash word, big-endian byte order
	typedef logic [31:0] word_t;

	// Valid bytes in a word, 0 to 4, taken from the top byte down
	typedef logic [2:0] byte_cnt_t;

	// Final digest, word a in bits 255:224
	typedef logic [255:0] digest_t;

	// Message length in bytes
	typedef logic [31:0] msg_len_t;

	// Lane number
	typedef logic [1:0] lane_idx_t;

	// Credit counters, wide enough to hold 16
	typedef logic [4:0] credit_cnt_t;

	////////////////////////////////////////////////////////////
	// Array sizing and credit pools

	// Hashing lanes in the array
	localparam int NUM_LANES = 4;
	// Dispatcher word buffer, also the sender credit pool
	localparam int IN_DEPTH = 16;
	// Block buffer in each lane, also the per-lane credit pool
	localparam int LANE_DEPTH = 16;
	// Digests in flight toward the receiver
	localparam int OUT_CREDITS = 2;

	// Lane FSM
	typedef enum logic [2:0] {
		IDLE,
		FILL,
		PAD,
		PRECOMPUTE,
		COMPRESS,
		BLOCK_DONE,
		DONE
	} lane_state_t;

endpackage

`default_nettype wire

// ==== hw/sha256_msg_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha256_msg_dispatch (
	input  wire                           clk,
	input  wire                           rst,
	input  wire                           in_valid,
	input  wire sha_pkg::word_t           in_word,
	input  wire sha_pkg::byte_cnt_t       in_bytes,
	input  wire                           in_last,
	input  wire [sha_pkg::NUM_LANES-1:0]  lane_credit,
	output logic                          in_credit,
	output logic [sha_pkg::NUM_LANES-1:0] lane_valid,
	output sha_pkg::word_t                lane_word,
	output sha_pkg::byte_cnt_t            lane_bytes,
	output logic                          lane_last
);

	////////////////////////////////////////////////////////////
	// Input word buffer

	sha_pkg::word_t     fifo_word  [sha_pkg::IN_DEPTH];
	sha_pkg::byte_cnt_t fifo_bytes [sha_pkg::IN_DEPTH];
	logic               fifo_last  [sha_pkg::IN_DEPTH];

	logic [$clog2(sha_pkg::IN_DEPTH)-1:0] wr_ptr;
	logic [$clog2(sha_pkg::IN_DEPTH)-1:0] rd_ptr;
	logic [$clog2(sha_pkg::IN_DEPTH):0]   count;

	// Credits held toward each lane
	sha_pkg::credit_cnt_t lane_cred [sha_pkg::NUM_LANES];
	// Lane that owns the message at the head of the buffer
	sha_pkg::lane_idx_t   target;
	logic                 pop;

	// Head word leaves when the target lane has room
	assign pop       = (count != '0) && (lane_cred[target] != '0);
	// Each pop frees one slot for the sender
	assign in_credit = pop;

	// Head word is broadcast, only the target lane sees valid
	assign lane_word  = fifo_word[rd_ptr];
	assign lane_bytes = fifo_bytes[rd_ptr];
	assign lane_last  = fifo_last[rd_ptr];

	always_comb begin
		for (int i = 0; i < sha_pkg::NUM_LANES; i++) begin
			lane_valid[i] = pop && (target == sha_pkg::lane_idx_t'(i));
		end
	end

	// Storage only, the sender never overruns its credits
	always_ff @(posedge clk) begin
		if (in_valid) begin
			fifo_word[wr_ptr]  <= in_word;
			fifo_bytes[wr_ptr] <= in_bytes;
			fifo_last[wr_ptr]  <= in_last;
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers, occupancy, lane credits and round-robin target

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			target <= '0;
			for (int i = 0; i < sha_pkg::NUM_LANES; i++) begin
				lane_cred[i] <= sha_pkg::credit_cnt_t'(sha_pkg::LANE_DEPTH);
			end
		end else begin
			if (in_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Whole messages stay on one lane, move on after the last word
			if (pop && fifo_last[rd_ptr]) begin
				target <= (target == sha_pkg::NUM_LANES - 1) ? '0 : target + 1'b1;
			end
			// Spend on send, earn back as the lane drains its block buffer
			for (int i = 0; i < sha_pkg::NUM_LANES; i++) begin
				lane_cred[i] <= lane_cred[i]
					+ sha_pkg::credit_cnt_t'(lane_credit[i])
					- sha_pkg::credit_cnt_t'(lane_valid[i]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/sha256_lane.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha256_lane (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     word_valid,
	input  wire sha_pkg::word_t     word,
	input  wire sha_pkg::byte_cnt_t bytes,
	input  wire                     last,
	input  wire                     digest_take,
	output logic                    word_credit,
	output logic                    digest_ready,
	output sha_pkg::digest_t        digest
);

	`include "sha256_k.svh"

	////////////////////////////////////////////////////////////
	// Round helpers

	function automatic sha_pkg::word_t rotr(input sha_pkg::word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Upper case sigma, used on a and e
	function automatic sha_pkg::word_t bsig0(input sha_pkg::word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic sha_pkg::word_t bsig1(input sha_pkg::word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	// Lower case sigma, message schedule
	function automatic sha_pkg::word_t ssig0(input sha_pkg::word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic sha_pkg::word_t ssig1(input sha_pkg::word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	////////////////////////////////////////////////////////////
	// Block buffer, filled by the dispatcher under credits

	sha_pkg::word_t     fifo_word  [sha_pkg::LANE_DEPTH];
	sha_pkg::byte_cnt_t fifo_bytes [sha_pkg::LANE_DEPTH];
	logic               fifo_last  [sha_pkg::LANE_DEPTH];

	logic [$clog2(sha_pkg::LANE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(sha_pkg::LANE_DEPTH)-1:0] rd_ptr;
	logic [$clog2(sha_pkg::LANE_DEPTH):0]   count;

	sha_pkg::lane_state_t state;
	logic                 start;
	logic                 pop;

	// Words placed in W for this block, 0 to 16
	logic [4:0]        fill_cnt;
	logic [5:0]        round;
	sha_pkg::msg_len_t msg_len;
	// Last word of the message is already in W
	logic              msg_end;
	// The 0x80 marker has been written
	logic              pad_done;
	logic              last_block;
	logic              put_80;
	logic              put_len;

	// Schedule window, w[0] is W[t] during round t
	sha_pkg::word_t w     [16];
	sha_pkg::word_t w_pad [16];
	sha_pkg::word_t w_next;

	// Chaining values and working variables
	sha_pkg::word_t hc [8];
	sha_pkg::word_t a, b, c, d, e, f, g, h;
	// h + K + W for the coming round
	sha_pkg::word_t hkw;
	sha_pkg::word_t t1;
	sha_pkg::word_t t2;

	// New message only once the previous digest is gone
	assign start       = (state == sha_pkg::IDLE) && (count != '0) && !digest_ready;
	assign pop         = (state == sha_pkg::FILL) && (count != '0);
	assign word_credit = pop;
	assign digest      = {hc[0], hc[1], hc[2], hc[3], hc[4], hc[5], hc[6], hc[7]};

	always_ff @(posedge clk) begin
		if (word_valid) begin
			fifo_word[wr_ptr]  <= word;
			fifo_bytes[wr_ptr] <= bytes;
			fifo_last[wr_ptr]  <= last;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (word_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({word_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Padding

	// Marker fits unless a full 64-byte block ended the message
	assign put_80  = msg_end && !pad_done && ((msg_len[5:0] != 6'd0) || (fill_cnt != 5'd16));
	// Length needs bytes 56 to 63 free; second block always has room
	assign put_len = msg_end && (pad_done || (put_80 && (msg_len[5:0] <= 6'd55)));

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			// Unfilled words are cleared
			w_pad[i] = (i < fill_cnt) ? w[i] : '0;
			if (put_80 && (i == msg_len[5:2])) begin
				// Keep the valid bytes, marker right after them
				case (msg_len[1:0])
					2'd0: w_pad[i] = 32'h8000_0000;
					2'd1: w_pad[i] = {w[i][31:24], 24'h80_0000};
					2'd2: w_pad[i] = {w[i][31:16], 16'h8000};
					2'd3: w_pad[i] = {w[i][31:8], 8'h80};
				endcase
			end
		end
		// 64-bit big-endian bit count, top bits always zero here
		if (put_len) begin
			w_pad[14] = {29'd0, msg_len[31:29]};
			w_pad[15] = {msg_len[28:0], 3'd0};
		end
	end

	////////////////////////////////////////////////////////////
	// Round datapath

	assign w_next = ssig1(w[14]) + w[9] + ssig0(w[1]) + w[0];
	assign t1     = bsig1(e) + ((e & f) ^ (~e & g)) + hkw;
	assign t2     = bsig0(a) + ((a & b) ^ (a & c) ^ (b & c));

	////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= sha_pkg::IDLE;
			digest_ready <= 1'b0;
			fill_cnt     <= '0;
			round        <= '0;
			msg_end      <= 1'b0;
			pad_done     <= 1'b0;
			last_block   <= 1'b0;
		end else begin
			if (digest_take) begin
				digest_ready <= 1'b0;
			end
			case (state)
				sha_pkg::IDLE: begin
					if (start) begin
						fill_cnt   <= '0;
						msg_end    <= 1'b0;
						pad_done   <= 1'b0;
						last_block <= 1'b0;
						state      <= sha_pkg::FILL;
					end
				end
				sha_pkg::FILL: begin
					if (pop) begin
						fill_cnt <= fill_cnt + 1'b1;
						if (fifo_last[rd_ptr]) begin
							msg_end <= 1'b1;
							state   <= sha_pkg::PAD;
						end else if (fill_cnt == 5'd15) begin
							state <= sha_pkg::PAD;
						end
					end
				end
				sha_pkg::PAD: begin
					if (put_80) begin
						pad_done <= 1'b1;
					end
					last_block <= put_len;
					state      <= sha_pkg::PRECOMPUTE;
				end
				sha_pkg::PRECOMPUTE: begin
					round <= '0;
					state <= sha_pkg::COMPRESS;
				end
				sha_pkg::COMPRESS: begin
					round <= round + 1'b1;
					if (round == 6'd63) begin
						state <= sha_pkg::BLOCK_DONE;
					end
				end
				sha_pkg::BLOCK_DONE: begin
					fill_cnt <= '0;
					// Padding that did not fit goes in an extra block
					if (last_block) begin
						state <= sha_pkg::DONE;
					end else if (msg_end) begin
						state <= sha_pkg::PAD;
					end else begin
						state <= sha_pkg::FILL;
					end
				end
				sha_pkg::DONE: begin
					digest_ready <= 1'b1;
					state        <= sha_pkg::IDLE;
				end
				default: state <= sha_pkg::IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Hash datapath

	always_ff @(posedge clk) begin
		case (state)
			sha_pkg::IDLE: begin
				if (start) begin
					msg_len <= '0;
					for (int i = 0; i < 8; i++) begin
						hc[i] <= sha256_h0[i];
					end
				end
			end
			sha_pkg::FILL: begin
				if (pop) begin
					w[fill_cnt[3:0]] <= fifo_word[rd_ptr];
					msg_len          <= msg_len + sha_pkg::msg_len_t'(fifo_bytes[rd_ptr]);
				end
			end
			sha_pkg::PAD: begin
				for (int i = 0; i < 16; i++) begin
					w[i] <= w_pad[i];
				end
			end
			sha_pkg::PRECOMPUTE: begin
				hkw <= hc[7] + sha256_k[0] + w[0];
				a   <= hc[0];
				b   <= hc[1];
				c   <= hc[2];
				d   <= hc[3];
				e   <= hc[4];
				f   <= hc[5];
				g   <= hc[6];
				h   <= hc[7];
			end
			sha_pkg::COMPRESS: begin
				// Slide the window and extend the schedule in place
				for (int i = 0; i < 15; i++) begin
					w[i] <= w[i + 1];
				end
				if (round < 6'd48) begin
					w[15] <= w_next;
				end
				// Next round's h is today's g; index wraps harmlessly at round 63
				hkw <= g + sha256_k[round + 6'd1] + w[1];
				h   <= g;
				g   <= f;
				f   <= e;
				e   <= d + t1;
				d   <= c;
				c   <= b;
				b   <= a;
				a   <= t1 + t2;
			end
			sha_pkg::BLOCK_DONE: begin
				hc[0] <= hc[0] + a;
				hc[1] <= hc[1] + b;
				hc[2] <= hc[2] + c;
				hc[3] <= hc[3] + d;
				hc[4] <= hc[4] + e;
				hc[5] <= hc[5] + f;
				hc[6] <= hc[6] + g;
				hc[7] <= hc[7] + h;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/sha256_digest_collect.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha256_digest_collect (
	input  wire                                                   clk,
	input  wire                                                   rst,
	input  wire [sha_pkg::NUM_LANES-1:0]                          digest_ready,
	input  wire [sha_pkg::NUM_LANES*$bits(sha_pkg::digest_t)-1:0] lane_digest,
	input  wire                                                   out_credit,
	output logic [sha_pkg::NUM_LANES-1:0]                         digest_take,
	output logic                                                  out_valid,
	output sha_pkg::digest_t                                      out_digest
);

	////////////////////////////////////////////////////////////
	// In-order pick under receiver credits

	// Lane holding the oldest outstanding message
	sha_pkg::lane_idx_t   ptr;
	sha_pkg::credit_cnt_t credits;
	logic                 take;

	assign take = digest_ready[ptr] && (credits != '0);

	// At most one lane is released per cycle
	always_comb begin
		for (int i = 0; i < sha_pkg::NUM_LANES; i++) begin
			digest_take[i] = take && (ptr == sha_pkg::lane_idx_t'(i));
		end
	end

	// Digest register, refreshed on each take
	always_ff @(posedge clk) begin
		if (take) begin
			out_digest <= lane_digest[ptr*$bits(sha_pkg::digest_t) +: $bits(sha_pkg::digest_t)];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr       <= '0;
			credits   <= sha_pkg::credit_cnt_t'(sha_pkg::OUT_CREDITS);
			out_valid <= 1'b0;
		end else begin
			// one-cycle strobe
			out_valid <= take;
			if (take) begin
				ptr <= (ptr == sha_pkg::NUM_LANES - 1) ? '0 : ptr + 1'b1;
			end
			case ({out_credit, take})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/sha256_hash_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha256_hash_array (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     in_valid,
	input  wire sha_pkg::word_t     in_word,
	input  wire sha_pkg::byte_cnt_t in_bytes,
	input  wire                     in_last,
	input  wire                     out_credit,
	output wire                     in_credit,
	output wire                     out_valid,
	output wire sha_pkg::digest_t   out_digest
);

	////////////////////////////////////////////////////////////
	// Dispatcher to lanes, word bus shared by all lanes

	wire [sha_pkg::NUM_LANES-1:0] lane_valid;
	wire [sha_pkg::NUM_LANES-1:0] lane_credit;
	wire sha_pkg::word_t          lane_word;
	wire sha_pkg::byte_cnt_t      lane_bytes;
	wire                          lane_last;

	// Lanes to collector
	wire [sha_pkg::NUM_LANES-1:0]                          digest_ready;
	wire [sha_pkg::NUM_LANES-1:0]                          digest_take;
	wire [sha_pkg::NUM_LANES*$bits(sha_pkg::digest_t)-1:0] lane_digest;

	sha256_msg_dispatch u_dispatch (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_word     (in_word),
		.in_bytes    (in_bytes),
		.in_last     (in_last),
		.lane_credit (lane_credit),
		.in_credit   (in_credit),
		.lane_valid  (lane_valid),
		.lane_word   (lane_word),
		.lane_bytes  (lane_bytes),
		.lane_last   (lane_last)
	);

	// Identical lanes, each owns one slice of the digest bus
	for (genvar i = 0; i < sha_pkg::NUM_LANES; i++) begin : g_lane
		sha256_lane u_lane (
			.clk          (clk),
			.rst          (rst),
			.word_valid   (lane_valid[i]),
			.word         (lane_word),
			.bytes        (lane_bytes),
			.last         (lane_last),
			.digest_take  (digest_take[i]),
			.word_credit  (lane_credit[i]),
			.digest_ready (digest_ready[i]),
			.digest       (lane_digest[i*$bits(sha_pkg::digest_t) +: $bits(sha_pkg::digest_t)])
		);
	end

	sha256_digest_collect u_collect (
		.clk          (clk),
		.rst          (rst),
		.digest_ready (digest_ready),
		.lane_digest  (lane_digest),
		.out_credit   (out_credit),
		.digest_take  (digest_take),
		.out_valid    (out_valid),
		.out_digest   (out_digest)
	);

endmodule

`default_nettype wire

// ==== sim/sha256_hash_array_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module sha256_hash_array_asserts (
	input wire                          clk,
	input wire                          rst,
	input wire                          in_valid,
	input wire                          in_credit,
	input wire                          out_valid,
	input wire                          out_credit,
	input wire [sha_pkg::NUM_LANES-1:0] digest_take
);

	////////////////////////////////////////////////////////////
	// Credit pools as seen from outside the engine

	// Sender side, full buffer after reset
	int send_cred;
	// Receiver side, counted at out_valid
	int recv_cred;

	// Lane whose digest is due next in submission order
	sha_pkg::lane_idx_t          exp_lane;
	logic [sha_pkg::NUM_LANES-1:0] exp_take;

	always_comb begin
		for (int i = 0; i < sha_pkg::NUM_LANES; i++) begin
			exp_take[i] = (exp_lane == sha_pkg::lane_idx_t'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			send_cred <= sha_pkg::IN_DEPTH;
			recv_cred <= sha_pkg::OUT_CREDITS;
			exp_lane  <= '0;
		end else begin
			send_cred <= send_cred + int'(in_credit) - int'(in_valid);
			recv_cred <= recv_cred + int'(out_credit) - int'(out_valid);
			if (digest_take != '0) begin
				exp_lane <= (exp_lane == sha_pkg::NUM_LANES - 1) ? '0 : exp_lane + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Protocol properties

	assert property (@(posedge clk) disable iff (rst) in_valid |-> (send_cred > 0))
		else $error("in_valid asserted while the sender holds no credit");

	assert property (@(posedge clk) disable iff (rst) out_valid |-> (recv_cred > 0))
		else $error("out_valid asserted while the collector holds no credit");

	// At most one lane released per cycle, and only the lane due next
	assert property (@(posedge clk) disable iff (rst)
		(digest_take == '0) || (digest_take == exp_take))
		else $error("digest_take is not zero or the one-hot of the lane due next");

endmodule

bind sha256_hash_array sha256_hash_array_asserts u_asserts (
	.clk         (clk),
	.rst         (rst),
	.in_valid    (in_valid),
	.in_credit   (in_credit),
	.out_valid   (out_valid),
	.out_credit  (out_credit),
	.digest_take (digest_take)
);

`default_nettype wire

// ==== sim/tb_sha256_hash_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_sha256_hash_array;

	// Cycle budget per message, two blocks plus fill and collect
	localparam int MSG_BUDGET  = 200;
	localparam int BP_MSGS     = 20;
	localparam int HOLD_CYCLES = 1000;
	// in_credit must have been silent this long under back-pressure
	localparam int QUIET_MIN   = 200;
	localparam int NUM_MSGS    = 3 + 8 + BP_MSGS;
	localparam int WATCHDOG_CYCLES = NUM_MSGS * MSG_BUDGET + HOLD_CYCLES + 2000;

	logic                clk;
	logic                rst;
	logic                in_valid;
	sha_pkg::word_t      in_word;
	sha_pkg::byte_cnt_t  in_bytes;
	logic                in_last;
	logic                out_credit;
	wire                 in_credit;
	wire                 out_valid;
	wire sha_pkg::digest_t out_digest;

	// Expected digests in submission order
	sha_pkg::digest_t exp_q [$];
	int digest_errors = 0;
	int other_errors  = 0;
	int got_cnt       = 0;
	int send_cred;
	int quiet_cycles;
	// Receiver behavior, changed on the rising edge only
	logic rx_hold   = 1'b0;
	logic rx_random = 1'b0;
	integer seed    = 32'hfd18;

	sha256_hash_array u_sha256_hash_array (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_word    (in_word),
		.in_bytes   (in_bytes),
		.in_last    (in_last),
		.out_credit (out_credit),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_digest (out_digest)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference vectors, FIPS 180-2

	function automatic string msg_text(input int kind);
		case (kind)
			0: return "";
			1: return "abc";
			default: return "abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq";
		endcase
	endfunction

	function automatic sha_pkg::digest_t known_digest(input int kind);
		case (kind)
			0: return 256'he3b0c442_98fc1c14_9afbf4c8_996fb924_27ae41e4_649b934c_a495991b_7852b855;
			1: return 256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;
			default: return 256'h248d6a61_d20638b8_e5c02693_0c3e6039_a33ce459_64ff2167_f6ecedd4_19db06c1;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Sender model

	// Pool bookkeeping on the rising edge, inputs are stable there
	always @(posedge clk) begin
		if (rst) begin
			send_cred    <= sha_pkg::IN_DEPTH;
			quiet_cycles <= 0;
		end else begin
			send_cred    <= send_cred + int'(in_credit) - int'(in_valid);
			quiet_cycles <= in_credit ? 0 : quiet_cycles + 1;
		end
	end

	// Called on a falling edge, returns on a falling edge
	task automatic send_word(input sha_pkg::word_t w, input sha_pkg::byte_cnt_t nb,
			input logic last);
		while (send_cred == 0) begin
			in_valid = 1'b0;
			@(negedge clk);
		end
		in_valid = 1'b1;
		in_word  = w;
		in_bytes = nb;
		in_last  = last;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// Big-endian packing, only the final word may be partial
	task automatic send_msg(input int kind);
		string          s;
		int             n;
		int             nb;
		sha_pkg::word_t w;
		s = msg_text(kind);
		n = s.len();
		exp_q.push_back(known_digest(kind));
		if (n == 0) begin
			send_word('0, '0, 1'b1);
		end else begin
			for (int i = 0; i < n; i += 4) begin
				nb = (n - i > 4) ? 4 : n - i;
				w  = '0;
				for (int j = 0; j < nb; j++) begin
					w = w | (sha_pkg::word_t'(s[i + j]) << (24 - 8 * j));
				end
				send_word(w, sha_pkg::byte_cnt_t'(nb), (i + 4 >= n));
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Receiver model, digest check and credit return

	initial begin : receiver
		int               owed;
		int               r;
		logic             grant;
		sha_pkg::digest_t exp_d;
		out_credit = 1'b0;
		owed       = 0;
		forever begin
			@(negedge clk);
			out_credit = 1'b0;
			if (rst) begin
				owed = 0;
			end else begin
				if (out_valid) begin
					assert (exp_q.size() != 0) else begin
						other_errors++;
						$display("Digest arrived at %0t with no message outstanding", $time);
					end
					if (exp_q.size() != 0) begin
						exp_d = exp_q.pop_front();
						assert (out_digest == exp_d) else begin
							digest_errors++;
							$display("Error: %0t out_digest expected %h got %h",
								$time, exp_d, out_digest);
						end
					end
					got_cnt++;
					owed++;
				end
				if (!rx_hold && owed > 0) begin
					grant = 1'b1;
					// Random credit delay, about one grant in four cycles
					if (rx_random) begin
						r     = $random(seed);
						grant = (r[1:0] == 2'b00);
					end
					if (grant) begin
						out_credit = 1'b1;
						owed--;
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic wait_drained(input int max_cycles, input string what);
		int n;
		n = 0;
		@(posedge clk);
		while (exp_q.size() != 0 && n < max_cycles) begin
			@(posedge clk);
			n++;
		end
		assert (exp_q.size() == 0) else begin
			other_errors++;
			$display("Timed out in %s with %0d digest(s) missing", what, exp_q.size());
		end
		@(negedge clk);
	endtask

	// Padding-only block
	task automatic test_empty();
		send_msg(0);
		wait_drained(MSG_BUDGET, "empty message test");
	endtask

	// Partial last word
	task automatic test_abc();
		send_msg(1);
		wait_drained(MSG_BUDGET, "abc test");
	endtask

	// Length spills into a second block
	task automatic test_two_block();
		send_msg(2);
		wait_drained(MSG_BUDGET, "two-block test");
	endtask

	// Every lane gets used, digests must come back in order
	task automatic test_back_to_back();
		for (int i = 0; i < 8; i++) begin
			send_msg(i % 3);
		end
		wait_drained(8 * MSG_BUDGET, "back-to-back test");
	endtask

	task automatic test_backpressure();
		int got_before;
		int got_held;
		@(posedge clk);
		rx_hold    = 1'b1;
		got_before = got_cnt;
		@(negedge clk);
		// Mix of long and short messages so order is visible
		fork
			begin
				for (int i = 0; i < BP_MSGS; i++) begin
					send_msg((i % 3 == 2) ? 1 : 2);
				end
			end
		join_none
		repeat (HOLD_CYCLES) @(negedge clk);
		assert (quiet_cycles >= QUIET_MIN) else begin
			other_errors++;
			$display("in_credit still pulsing after %0d cycles of back-pressure", HOLD_CYCLES);
		end
		assert (send_cred == 0) else begin
			other_errors++;
			$display("Sender still holds %0d credits under back-pressure", send_cred);
		end
		@(posedge clk);
		got_held = got_cnt - got_before;
		assert (got_held <= sha_pkg::OUT_CREDITS) else begin
			other_errors++;
			$display("%0d digests delivered without credit return", got_held);
		end
		rx_random = 1'b1;
		rx_hold   = 1'b0;
		@(negedge clk);
		wait_drained(BP_MSGS * MSG_BUDGET, "back-pressure release");
		@(posedge clk);
		assert (got_cnt - got_before == BP_MSGS) else begin
			other_errors++;
			$display("Back-pressure test received %0d of %0d digests",
				got_cnt - got_before, BP_MSGS);
		end
		@(negedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		rst      = 1'b1;
		in_valid = 1'b0;
		in_word  = '0;
		in_bytes = '0;
		in_last  = 1'b0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		test_empty();
		test_abc();
		test_two_block();
		test_back_to_back();
		test_backpressure();
		repeat (10) @(negedge clk);
		$display("Errors: %0d digest mismatches, %0d other failures",
			digest_errors, other_errors);
		if (digest_errors == 0 && other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
		$display("Errors: %0d digest mismatches, %0d other failures",
			digest_errors, other_errors + 1);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
hw/sha_pkg.sv
hw/sha256_msg_dispatch.sv
hw/sha256_lane.sv
hw/sha256_digest_collect.sv
hw/sha256_hash_array.sv
sim/sha256_hash_array_asserts.sv
sim/tb_sha256_hash_array.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SHA-256 hash array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module tb_sha256_hash_array \
	-Mdir "$OBJ"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_sha256_hash_array" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
	exit 0
fi
exit 1
